/* design/exec_consts.svh */
//////////////////////////////////////////////////
// Execute unit constants
// Register and word widths, and the iteration
// counts of the multiply/divide unit.
//////////////////////////////////////////////////

`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

`define XLEN 64        // Register width of the RV64 core.
`define WLEN 32        // Operand width of the W forms.

// One iteration per result bit.
`define MD_STEPS   64
`define MD_STEPS_W 32

`endif

/* design/exec_pkg.sv */
//////////////////////////////////////////////////
// Execute unit package
// Instruction views, request bundle and the
// control words passed between the blocks.
//////////////////////////////////////////////////

`include "exec_consts.svh"

package exec_pkg;

    // Opcode groups handled by the execute unit.
    localparam logic [6:0] OP        = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_32     = 7'b0111011;
    localparam logic [6:0] OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] LUI       = 7'b0110111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;    // Also carries U-immediate bits 31:20.
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // The same instruction word seen as R type or I type.
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instr_t;

    typedef struct packed {
        instr_t             instr;
        logic [`XLEN-1:0]   rs1_val;
        logic [`XLEN-1:0]   rs2_val;
    } exec_req_t;

    typedef struct packed {
        logic is_div;      // Divide or remainder, otherwise multiply.
        logic is_rem;      // Remainder result.
        logic is_signed;   // Operands are two's complement.
        logic is_word;     // 32-bit W form.
    } md_ctl_t;

    // Bit 10 is the instruction's bit 30, then funct3, then opcode.
    typedef struct packed {
        logic       alt;
        logic [2:0] funct3;
        logic [6:0] opcode;
    } alu_ctl_t;

endpackage

/* design/operand_decode.sv */
//////////////////////////////////////////////////
// Operand decode
// Splits the instruction into the ALU control
// word, the two operands and the M-extension
// control bits.
//////////////////////////////////////////////////

`include "exec_consts.svh"

module operand_decode (
    input  exec_pkg::exec_req_t req,
    output exec_pkg::alu_ctl_t  alu_ctl,
    output logic [`XLEN-1:0]    op_a,
    output logic [`XLEN-1:0]    op_b,
    output logic                is_md,
    output exec_pkg::md_ctl_t   md_ctl
);
    import exec_pkg::*;

    instr_t           ir;
    logic [6:0]       opc;
    logic             reg_form;
    logic             imm_form;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;

    assign ir  = req.instr;
    assign opc = ir.r_view.opcode;   // Opcode sits in the same place in both views.

    assign reg_form = (opc == OP) || (opc == OP_32);
    assign imm_form = (opc == OP_IMM) || (opc == OP_IMM_32);

    // I immediate, sign extended from bit 31 of the instruction.
    assign imm_i = {{(`XLEN-12){ir.i_view.imm12[11]}}, ir.i_view.imm12};

    // U immediate is instruction bits 31:12 with twelve zeros below.
    assign imm_u = {{(`XLEN-32){ir.i_view.imm12[11]}}, ir.i_view.imm12,
                    ir.i_view.rs1, ir.i_view.funct3, 12'b0};

    always_comb begin
        alu_ctl.opcode = opc;
        alu_ctl.funct3 = ir.r_view.funct3;   // Same field position in both views.
        // Bit 30 selects SUB and SRA in R forms, SRAI in the immediate forms.
        if (reg_form) alu_ctl.alt = ir.r_view.funct7[5];
        else          alu_ctl.alt = imm_form && ir.i_view.imm12[10];
    end

    assign op_a = req.rs1_val;
    assign op_b = (opc == LUI) ? imm_u :
                  imm_form     ? imm_i : req.rs2_val;

    // M extension lives in OP and OP-32 with funct7 set to one.
    assign is_md = reg_form && (ir.r_view.funct7 == 7'b0000001);

    always_comb begin
        md_ctl.is_div    = ir.r_view.funct3[2];                          // DIV, DIVU, REM, REMU.
        md_ctl.is_rem    = ir.r_view.funct3[2] && ir.r_view.funct3[1];   // REM and REMU.
        md_ctl.is_signed = !ir.r_view.funct3[0];                         // Odd funct3 is unsigned.
        md_ctl.is_word   = (opc == OP_32);
    end

endmodule

/* design/alu.sv */
//////////////////////////////////////////////////
// RV64I ALU
// Combinational add, subtract, shift, compare,
// logic and LUI, with 32-bit W forms.
//////////////////////////////////////////////////

`include "exec_consts.svh"

module alu (
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    input  exec_pkg::alu_ctl_t ctl,
    output logic [`XLEN-1:0]  alu_out
);
    import exec_pkg::*;

    logic             reg_form;   // SUB exists only for the register forms.
    logic [`WLEN-1:0] w_res;

    assign reg_form = (ctl.opcode == OP) || (ctl.opcode == OP_32);

    always_comb begin
        w_res   = '0;
        alu_out = a + b;   // Anything else decodes as an add.
        case (ctl.opcode)
            LUI: alu_out = b;   // Immediate already shifted into place.
            OP, OP_IMM: begin
                case (ctl.funct3)
                    3'b000: alu_out = (reg_form && ctl.alt) ? a - b : a + b;
                    3'b001: alu_out = a << b[5:0];
                    3'b010: alu_out = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                    3'b011: alu_out = {{(`XLEN-1){1'b0}}, a < b};
                    3'b100: alu_out = a ^ b;
                    3'b101: begin
                        // Each shift in its own statement keeps the signed operand signed.
                        if (ctl.alt) alu_out = $signed(a) >>> b[5:0];
                        else         alu_out = a >> b[5:0];
                    end
                    3'b110: alu_out = a | b;
                    3'b111: alu_out = a & b;
                    default: alu_out = a + b;
                endcase
            end
            OP_32, OP_IMM_32: begin
                // W forms work on the low word and shift by five bits.
                case (ctl.funct3)
                    3'b000: begin
                        if (reg_form && ctl.alt) w_res = a[`WLEN-1:0] - b[`WLEN-1:0];
                        else                     w_res = a[`WLEN-1:0] + b[`WLEN-1:0];
                    end
                    3'b001: w_res = a[`WLEN-1:0] << b[4:0];
                    3'b101: begin
                        if (ctl.alt) w_res = $signed(a[`WLEN-1:0]) >>> b[4:0];
                        else         w_res = a[`WLEN-1:0] >> b[4:0];
                    end
                    default: w_res = a[`WLEN-1:0] + b[`WLEN-1:0];
                endcase
                alu_out = {{(`XLEN-`WLEN){w_res[`WLEN-1]}}, w_res};   // Sign extend the word.
            end
            default: ;
        endcase
    end

endmodule

/* design/md_fsm.sv */
//////////////////////////////////////////////////
// Multiply/divide sequencer
// Idle, load, run and done. One load, a run of
// steps ended by the counter, then one finish.
//////////////////////////////////////////////////

`include "exec_consts.svh"

module md_fsm (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic is_word,
    input  logic last,
    output logic load,
    output logic step,
    output logic finish,
    output logic cnt_clear,
    output logic cnt_en,
    output logic busy
);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] LOAD = 2'd1;
    localparam logic [1:0] RUN  = 2'd2;
    localparam logic [1:0] DONE = 2'd3;

    logic [1:0] state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (start) state <= LOAD;
                LOAD: state <= RUN;              // Exactly one load cycle.
                RUN:  if (last) state <= DONE;   // Counter ends the run.
                DONE: state <= IDLE;             // Result is taken on this edge.
                default: state <= IDLE;
            endcase
        end
    end

    assign load      = (state == LOAD);
    assign cnt_clear = (state == LOAD);   // Counter is preset alongside the load.
    assign step      = (state == RUN);
    assign cnt_en    = (state == RUN);
    assign finish    = (state == DONE);
    assign busy      = (state != IDLE);

    // A new operation may only start once the previous one has finished.
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> (state == IDLE));

    // Last step falls S cycles after the load, for either width.
    a_full_len: assert property (@(posedge clk) disable iff (rst)
        load && !is_word |-> ##(`MD_STEPS) last);
    a_word_len: assert property (@(posedge clk) disable iff (rst)
        load && is_word |-> ##(`MD_STEPS_W) last);

endmodule

/* design/step_counter.sv */
//////////////////////////////////////////////////
// Step counter
// Down-counter of multiply/divide iterations,
// flags the final step.
//////////////////////////////////////////////////

`include "exec_consts.svh"

module step_counter (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic en,
    input  logic is_word,
    output logic last
);

    logic [6:0] cnt;   // Holds up to 64.

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (clear) begin
            cnt <= is_word ? 7'(`MD_STEPS_W) : 7'(`MD_STEPS);
        end else if (en) begin
            cnt <= cnt - 7'd1;
        end
    end

    assign last = en && (cnt == 7'd1);   // High during the cycle of the final step.

endmodule

/* design/md_datapath.sv */
//////////////////////////////////////////////////
// Multiply/divide datapath
// Shift-add multiplier and restoring divider on
// operand magnitudes, one bit per step, with the
// sign fix and RISC-V special cases at the end.
//////////////////////////////////////////////////

`include "exec_consts.svh"

module md_datapath (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  logic              step,
    input  logic              finish,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    input  exec_pkg::md_ctl_t ctl,
    output logic [`XLEN-1:0]  md_result
);
    import exec_pkg::*;

    logic [`XLEN-1:0] a_x;       // Operands after W truncation.
    logic [`XLEN-1:0] b_x;
    logic             sign_a;
    logic             sign_b;
    logic [`XLEN-1:0] mag_a;
    logic [`XLEN-1:0] mag_b;
    logic [`XLEN-1:0] min_val;   // Most negative value of the operation width.
    logic [`XLEN-1:0] acc;       // Product, or partial remainder.
    logic [`XLEN-1:0] mq;        // Multiplier, or dividend turning into quotient.
    logic [`XLEN-1:0] mcand;     // Multiplicand, or divisor.
    logic             res_neg;
    logic             div_zero;
    logic             ovf;
    logic [`XLEN:0]   trial;     // One extra bit holds the borrow.
    logic [`XLEN-1:0] mag_res;
    logic [`XLEN-1:0] sel_res;

    function automatic logic [`XLEN-1:0] word_ext(input logic [`XLEN-1:0] v,
                                                  input logic sgn);
        return {{(`XLEN-`WLEN){sgn & v[`WLEN-1]}}, v[`WLEN-1:0]};
    endfunction

    assign a_x = ctl.is_word ? word_ext(a, ctl.is_signed) : a;
    assign b_x = ctl.is_word ? word_ext(b, ctl.is_signed) : b;

    assign sign_a = ctl.is_signed && a_x[`XLEN-1];
    assign sign_b = ctl.is_signed && b_x[`XLEN-1];
    assign mag_a  = sign_a ? -a_x : a_x;
    assign mag_b  = sign_b ? -b_x : b_x;

    assign min_val = ctl.is_word ? {{(`XLEN-`WLEN+1){1'b1}}, {(`WLEN-1){1'b0}}}
                                 : {1'b1, {(`XLEN-1){1'b0}}};

    // Shift the next dividend bit in and try the divisor.
    assign trial = {acc, mq[`XLEN-1]} - {1'b0, mcand};

    always_ff @(posedge clk) begin
        if (load) begin
            acc <= '0;
            if (ctl.is_div) begin
                // W dividend goes to the top so 32 steps consume it.
                mq    <= ctl.is_word ? {mag_a[`WLEN-1:0], {(`XLEN-`WLEN){1'b0}}} : mag_a;
                mcand <= mag_b;
            end else begin
                mq    <= mag_b;
                mcand <= mag_a;
            end
            res_neg  <= ctl.is_rem ? sign_a : (sign_a ^ sign_b);   // Remainder takes the dividend sign.
            div_zero <= (b_x == '0);
            ovf      <= ctl.is_signed && (a_x == min_val) && (b_x == '1);
        end else if (step) begin
            if (ctl.is_div) begin
                // Restore on borrow, otherwise keep the difference.
                acc <= trial[`XLEN] ? {acc[`XLEN-2:0], mq[`XLEN-1]} : trial[`XLEN-1:0];
                mq  <= {mq[`XLEN-2:0], ~trial[`XLEN]};
            end else begin
                if (mq[0]) acc <= acc + mcand;
                mq    <= mq >> 1;
                mcand <= mcand << 1;
            end
        end
    end

    always_comb begin
        mag_res = (ctl.is_div && !ctl.is_rem) ? mq : acc;
        sel_res = res_neg ? -mag_res : mag_res;
        if (ctl.is_div && div_zero) begin
            sel_res = ctl.is_rem ? a_x : '1;       // x/0 gives all ones, x%0 gives x.
        end else if (ctl.is_div && ovf) begin
            sel_res = ctl.is_rem ? '0 : min_val;   // MIN/-1 gives MIN with zero remainder.
        end
        md_result = ctl.is_word ? word_ext(sel_res, 1'b1) : sel_res;
    end

    // The result is read only right after the last iteration.
    a_finish_after_step: assert property (@(posedge clk) disable iff (rst)
        finish |-> $past(step));

endmodule

/* design/exec_unit.sv */
//////////////////////////////////////////////////
// Integer execute unit
// Takes one instruction with its operands, runs
// it on the ALU or the multiply/divide unit, and
// returns the registered result with a strobe.
//////////////////////////////////////////////////

`include "exec_consts.svh"

module exec_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  exec_pkg::exec_req_t req,
    output logic [`XLEN-1:0]    result,
    output logic                out_valid,
    output logic                busy
);
    import exec_pkg::*;

    alu_ctl_t         alu_ctl;
    md_ctl_t          md_ctl;
    md_ctl_t          md_ctl_q;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] alu_q;
    logic [`XLEN-1:0] md_a;
    logic [`XLEN-1:0] md_b;
    logic [`XLEN-1:0] md_result;
    logic             is_md;
    logic             accept;
    logic             start;
    logic             alu_v;   // ALU result waiting in alu_q.
    logic             load;
    logic             step;
    logic             finish;
    logic             cnt_clear;
    logic             cnt_en;
    logic             last;

    assign accept = in_valid && !busy;   // Requests during busy are dropped.
    assign start  = accept && is_md;

    operand_decode operand_decode_inst (
        .req(req), .alu_ctl(alu_ctl), .op_a(op_a), .op_b(op_b),
        .is_md(is_md), .md_ctl(md_ctl)
    );

    alu alu_inst (.a(op_a), .b(op_b), .ctl(alu_ctl), .alu_out(alu_out));

    md_fsm md_fsm_inst (
        .clk(clk), .rst(rst), .start(start), .is_word(md_ctl_q.is_word), .last(last),
        .load(load), .step(step), .finish(finish),
        .cnt_clear(cnt_clear), .cnt_en(cnt_en), .busy(busy)
    );

    step_counter step_counter_inst (
        .clk(clk), .rst(rst), .clear(cnt_clear), .en(cnt_en),
        .is_word(md_ctl_q.is_word), .last(last)
    );

    md_datapath md_datapath_inst (
        .clk(clk), .rst(rst), .load(load), .step(step), .finish(finish),
        .a(md_a), .b(md_b), .ctl(md_ctl_q), .md_result(md_result)
    );

    // Operands held steady for the whole multiply/divide.
    always_ff @(posedge clk) begin
        if (accept && !is_md) alu_q <= alu_out;
        if (start) begin
            md_a     <= op_a;
            md_b     <= op_b;
            md_ctl_q <= md_ctl;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_v     <= 1'b0;
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            alu_v     <= accept && !is_md;
            out_valid <= alu_v || finish;   // The two paths never finish together.
            if (alu_v)       result <= alu_q;
            else if (finish) result <= md_result;
        end
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !in_valid);

    // A multiply/divide result is a single-cycle pulse.
    a_md_single_pulse: assert property (@(posedge clk) disable iff (rst)
        finish |=> ##1 !out_valid);

endmodule

/* test/exec_unit_tb.sv */
//////////////////////////////////////////////////
// Execute unit testbench
// Random RV64IM instructions from an LFSR, each
// checked against a reference model for result,
// latency and the busy level.
//////////////////////////////////////////////////

`include "exec_consts.svh"

module exec_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    localparam int NUM_REQ        = 400;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = NUM_REQ * (`MD_STEPS + 4) + RESET_CYCLES;
    localparam int WAIT_LIMIT     = `MD_STEPS + 4;   // Longest wait for one result.
    localparam logic [63:0] MIN64 = 64'h8000_0000_0000_0000;
    localparam logic [63:0] MIN32 = 64'hffff_ffff_8000_0000;   // Sign-extended word minimum.

    logic             clk;
    logic             rst;
    logic             in_valid;
    exec_req_t        req;
    logic [`XLEN-1:0] result;
    logic             out_valid;
    logic             busy;

    logic [31:0] lfsr_state;
    int          error_count = 0;
    int          check_count = 0;
    int          accepted = 0;      // Requests handed to the DUT.
    int          pulse_count = 0;   // out_valid pulses seen.
    int          cycle_count;

    exec_unit exec_unit_inst (
        .clk(clk), .rst(rst), .in_valid(in_valid), .req(req),
        .result(result), .out_valid(out_valid), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period.
    end

    // Taps 32, 22, 2 and 1 give a maximal-length sequence.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};   // One step per bit taken.
        end
    endtask

    // Half of the operands are corner values.
    task automatic pick_operand(output logic [63:0] v);
        logic [63:0] sel;
        draw_bits(3, sel);
        case (sel[2:0])
            3'd0: v = '0;
            3'd1: v = '1;
            3'd2: v = MIN64;
            3'd3: v = MIN32;
            default: draw_bits(64, v);
        endcase
    endtask

    task automatic build_request(output logic [31:0] ins, output logic [63:0] a,
                                 output logic [63:0] b);
        logic [63:0] grp;
        logic [63:0] f3;
        logic [63:0] alt;
        logic [63:0] imm;
        logic [63:0] regs;   // rs2, rs1 and rd fields, ignored by the unit.
        logic [63:0] ovf;
        logic [2:0]  fw;     // W forms only have ADD, SLL and SRL/SRA.
        logic [2:0]  fm;
        logic [11:0] imm12;
        logic        alt_ok;
        pick_operand(a);
        pick_operand(b);
        draw_bits(3, grp);
        draw_bits(3, f3);
        draw_bits(1, alt);
        draw_bits(12, imm);
        draw_bits(15, regs);
        draw_bits(2, ovf);
        fw = (f3[1:0] == 2'd1) ? 3'b001 : (f3[1:0] == 2'd2) ? 3'b101 : 3'b000;
        case (f3[2:0])   // MULH variants fold onto the divide ops.
            3'd1: fm = 3'b100;
            3'd2: fm = 3'b110;
            3'd3: fm = 3'b101;
            default: fm = f3[2:0];
        endcase
        case (grp[2:0])
            3'd0, 3'd1: begin
                alt_ok = alt[0] && (f3[2:0] == 3'b000 || f3[2:0] == 3'b101);   // SUB, SRA.
                ins = {1'b0, alt_ok, 5'b0, regs[14:5], f3[2:0], regs[4:0], OP};
            end
            3'd2: begin
                if (f3[2:0] == 3'b001)      imm12 = {6'b0, imm[5:0]};
                else if (f3[2:0] == 3'b101) imm12 = {1'b0, alt[0], 4'b0, imm[5:0]};
                else                        imm12 = imm[11:0];
                ins = {imm12, regs[9:5], f3[2:0], regs[4:0], OP_IMM};
            end
            3'd3: begin
                alt_ok = alt[0] && (fw != 3'b001);
                ins = {1'b0, alt_ok, 5'b0, regs[14:5], fw, regs[4:0], OP_32};
            end
            3'd4: begin
                if (fw == 3'b001)      imm12 = {7'b0, imm[4:0]};
                else if (fw == 3'b101) imm12 = {1'b0, alt[0], 5'b0, imm[4:0]};
                else                   imm12 = imm[11:0];
                ins = {imm12, regs[9:5], fw, regs[4:0], OP_IMM_32};
            end
            3'd5: ins = {imm[11:0], regs[14:7], regs[4:0], LUI};
            default: begin
                ins = {7'b0000001, regs[14:5], fm, regs[4:0], grp[0] ? OP_32 : OP};
                if (ovf[1:0] == 2'b00) begin   // Quarter of M ops hit MIN / -1.
                    a = grp[0] ? MIN32 : MIN64;
                    b = '1;
                end
            end
        endcase
    endtask

    // Reference results from the RISC-V rules.
    function automatic logic [63:0] model_result(input logic [31:0] ins,
                                                 input logic [63:0] a,
                                                 input logic [63:0] rs2);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        m_op;
        logic [63:0] b;
        logic [63:0] res;
        logic [31:0] aw;
        logic [31:0] bw;
        logic [31:0] w;
        opc  = ins[6:0];
        f3   = ins[14:12];
        m_op = (ins[31:25] == 7'b0000001);
        b    = (opc == OP_IMM || opc == OP_IMM_32) ? {{52{ins[31]}}, ins[31:20]} : rs2;
        aw   = a[31:0];
        bw   = b[31:0];
        res  = '0;
        w    = '0;
        if (opc == LUI) begin
            res = {{32{ins[31]}}, ins[31:12], 12'b0};
        end else if (opc == OP && m_op) begin
            case (f3)
                3'b000: res = a * b;
                3'b100: begin
                    if (b == '0)                    res = '1;
                    else if (a == MIN64 && b == '1) res = MIN64;
                    else                            res = $signed(a) / $signed(b);
                end
                3'b101: res = (b == '0) ? '1 : a / b;
                3'b110: begin
                    if (b == '0)                    res = a;
                    else if (a == MIN64 && b == '1) res = '0;
                    else                            res = $signed(a) % $signed(b);
                end
                default: res = (b == '0) ? a : a % b;
            endcase
        end else if (opc == OP_32 && m_op) begin
            case (f3)
                3'b000: w = aw * bw;
                3'b100: begin
                    if (bw == '0)                            w = '1;
                    else if (aw == 32'h8000_0000 && bw == '1) w = 32'h8000_0000;
                    else                                     w = $signed(aw) / $signed(bw);
                end
                3'b101: w = (bw == '0) ? '1 : aw / bw;
                3'b110: begin
                    if (bw == '0)                            w = aw;
                    else if (aw == 32'h8000_0000 && bw == '1) w = '0;
                    else                                     w = $signed(aw) % $signed(bw);
                end
                default: w = (bw == '0) ? aw : aw % bw;
            endcase
            res = {{32{w[31]}}, w};
        end else if (opc == OP || opc == OP_IMM) begin
            case (f3)
                3'b000: res = (opc == OP && ins[30]) ? a - b : a + b;
                3'b001: res = a << b[5:0];
                3'b010: res = {63'b0, $signed(a) < $signed(b)};
                3'b011: res = {63'b0, a < b};
                3'b100: res = a ^ b;
                3'b101: begin
                    if (ins[30]) res = $signed(a) >>> b[5:0];
                    else         res = a >> b[5:0];
                end
                3'b110: res = a | b;
                default: res = a & b;
            endcase
        end else begin
            case (f3)   // OP-32 and OP-IMM-32.
                3'b000: w = (opc == OP_32 && ins[30]) ? aw - bw : aw + bw;
                3'b001: w = aw << b[4:0];
                default: begin
                    if (ins[30]) w = $signed(aw) >>> b[4:0];
                    else         w = aw >> b[4:0];
                end
            endcase
            res = {{32{w[31]}}, w};
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("[ERROR] t=%0t %s: expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count = error_count + 1;
        $display("t=%0t %s", $time, msg);
    endtask

    // Issues one request and follows it cycle by cycle until its result.
    task automatic run_request(input logic [31:0] ins, input logic [63:0] a,
                               input logic [63:0] b);
        logic [63:0] expected;
        logic        md;
        logic        word;
        logic        seen;
        int          lat_exp;
        int          k;          // Edges since the accepting edge.
        expected = model_result(ins, a, b);
        md       = (ins[6:0] == OP || ins[6:0] == OP_32) && (ins[31:25] == 7'b0000001);
        word     = (ins[6:0] == OP_32);
        lat_exp  = md ? (word ? `MD_STEPS_W + 2 : `MD_STEPS + 2) : 1;
        if (out_valid || busy) report_failure("DUT not idle before a new request");
        @(posedge clk);
        in_valid <= 1'b1;
        req      <= exec_req_t'({ins, a, b});
        @(posedge clk);                      // This edge accepts the request.
        in_valid <= 1'b0;
        accepted = accepted + 1;
        k    = 0;
        seen = 1'b0;
        while (!seen && k <= WAIT_LIMIT) begin
            @(negedge clk);
            check_value("busy", 64'(md && (k < lat_exp)), 64'(busy));
            if (out_valid) seen = 1'b1;
            else           k = k + 1;
        end
        if (!seen) begin
            report_failure($sformatf("missing out_valid for instruction %h", ins));
        end else begin
            check_value("latency", 64'(lat_exp), 64'(k));
            check_value($sformatf("result (instr %h)", ins), expected, result);
            @(negedge clk);
            if (out_valid) report_failure("unexpected out_valid in the cycle after a result");
        end
    endtask

    always @(negedge clk) begin
        if (!rst && out_valid) pulse_count <= pulse_count + 1;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] ins;
        logic [63:0] a;
        logic [63:0] b;
        int          n;
        lfsr_state = 32'h48d9_b2d9;
        rst        = 1'b1;
        in_valid   = 1'b0;
        req        = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("out_valid", 64'd0, 64'(out_valid));
        check_value("busy", 64'd0, 64'(busy));
        check_value("result", 64'd0, result);
        for (n = 0; n < NUM_REQ; n++) begin
            build_request(ins, a, b);
            run_request(ins, a, b);
        end
        @(posedge clk);
        check_value("out_valid pulse count", 64'(accepted), 64'(pulse_count));
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+design
design/exec_pkg.sv
design/operand_decode.sv
design/alu.sv
design/md_fsm.sv
design/step_counter.sv
design/md_datapath.sv
design/exec_unit.sv
test/exec_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module exec_unit_tb -f all.f \
    && ./obj_dir/Vexec_unit_tb | tee /dev/stderr | grep -q "^Simulation finished: PASS$" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
